//--- Bender.yml
package:
  name: banked_mem

sources:
  - common/banked_mem_pkg.sv
  - banked_mem/req_fifo.sv
  - banked_mem/bank_engine.sv
  - banked_mem/rsp_merge.sv
  - design/banked_mem_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/banked_mem_tb.sv

//--- banked_mem/bank_engine.sv
// ==============================
// open-page engine for one bank group
// serves its queue in order, one request at a time
// reads end with a one cycle rsp_valid pulse
// ==============================

`timescale 1ns/1ps

module bank_engine (
    input  logic                     itf,
    input  logic                     arst_n,
    input  banked_mem_pkg::mem_req_t head,
    input  logic                     nonempty,
    output logic                     pop,
    output logic                     rsp_valid,
    output banked_mem_pkg::mem_rsp_t rsp
);

    import banked_mem_pkg::*;

    bank_state_e state;
    mem_req_t    cur;

    logic [ROW_W-1:0]   open_row  [GROUP_BANKS];
    logic               row_valid [GROUP_BANKS];
    logic [CNT_W-1:0]   tras_cnt  [GROUP_BANKS];
    logic [CNT_W-1:0]   wait_cnt;

    // words indexed by {local bank, row, col}
    logic [DATA_W-1:0]  words [GROUP_BANKS * (2 ** ROW_W) * (2 ** COL_W)];

    logic [LBANK_W-1:0] hd_bank;
    logic [ROW_W-1:0]   hd_row;
    logic               hd_open;
    logic               hd_hit;
    logic [LBANK_W-1:0] cur_bank;
    logic [ROW_W-1:0]   cur_row;
    logic [COL_W-1:0]   cur_col;
    logic               pre_done;
    logic               act_load;
    logic [LBANK_W-1:0] act_bank;
    logic [ROW_W-1:0]   act_row;

    // upper bank bit selects the bank inside the group
    assign hd_bank  = head.addr[BANK_LSB+1 +: LBANK_W];
    assign hd_row   = head.addr[ROW_LSB +: ROW_W];
    assign cur_bank = cur.addr[BANK_LSB+1 +: LBANK_W];
    assign cur_row  = cur.addr[ROW_LSB +: ROW_W];
    assign cur_col  = cur.addr[COL_LSB +: COL_W];

    assign hd_open = row_valid[hd_bank];
    assign hd_hit  = hd_open && (open_row[hd_bank] == hd_row);

    assign pop = (state == IDLE) && nonempty;

    // last precharge cycle, tRAS already expired
    assign pre_done = (state == PRECHARGE) && (tras_cnt[cur_bank] == '0) && (wait_cnt == '0);

    // entering ACTIVATE, either straight from IDLE or after precharge
    assign act_load = (pop && !hd_open) || pre_done;
    assign act_bank = (state == IDLE) ? hd_bank : cur_bank;
    assign act_row  = (state == IDLE) ? hd_row : cur_row;

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            wait_cnt <= '0;
            for (int b = 0; b < GROUP_BANKS; b++) begin
                row_valid[b] <= 1'b0;
                tras_cnt[b]  <= '0;
            end
        end else begin
            for (int b = 0; b < GROUP_BANKS; b++) begin
                if (tras_cnt[b] != '0) begin
                    tras_cnt[b] <= tras_cnt[b] - 1'b1;
                end
            end
            case (state)
                IDLE: begin
                    if (pop) begin
                        if (hd_hit) begin
                            state    <= ACCESS;
                            wait_cnt <= head.read ? CNT_W'(T_CL - 1) : CNT_W'(T_WR - 1);
                        end else if (!hd_open) begin
                            state    <= ACTIVATE;
                            wait_cnt <= CNT_W'(T_RCD - 1);
                        end else begin
                            state    <= PRECHARGE;     // row conflict
                            wait_cnt <= CNT_W'(T_RP - 1);
                        end
                    end
                end
                PRECHARGE: begin
                    if (pre_done) begin
                        state    <= ACTIVATE;
                        wait_cnt <= CNT_W'(T_RCD - 1);
                    end else if (tras_cnt[cur_bank] == '0) begin
                        wait_cnt <= wait_cnt - 1'b1;   // holds while tRAS runs
                    end
                end
                ACTIVATE: begin
                    if (wait_cnt == '0) begin
                        state    <= ACCESS;
                        wait_cnt <= cur.read ? CNT_W'(T_CL - 1) : CNT_W'(T_WR - 1);
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                ACCESS: begin
                    if (wait_cnt == '0) begin
                        state <= COMPLETE;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                COMPLETE: state <= IDLE;
                default:  state <= IDLE;
            endcase
            if (act_load) begin
                row_valid[act_bank] <= 1'b1;
                tras_cnt[act_bank]  <= CNT_W'(T_RAS);
            end
        end
    end

    always_ff @(posedge itf) begin
        if (pop) begin
            cur <= head;
        end
        if (act_load) begin
            open_row[act_bank] <= act_row;
        end
        if ((state == COMPLETE) && !cur.read) begin
            words[{cur_bank, cur_row, cur_col}] <= cur.wdata;
        end
    end

    assign rsp_valid = (state == COMPLETE) && cur.read;
    assign rsp.raddr = cur.addr;
    assign rsp.rdata = words[{cur_bank, cur_row, cur_col}];

endmodule

//--- banked_mem/req_fifo.sv
// ==============================
// request queue for one bank group
// head is valid while nonempty is high
// space says two or more entries are free
// ==============================

`timescale 1ns/1ps

module req_fifo (
    input  logic                     itf,
    input  logic                     arst_n,
    input  logic                     push,
    input  banked_mem_pkg::mem_req_t push_req,
    input  logic                     pop,
    output banked_mem_pkg::mem_req_t head,
    output logic                     nonempty,
    output logic                     space
);

    import banked_mem_pkg::*;

    mem_req_t              entries [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge itf) begin
        if (push) begin
            entries[wr_ptr] <= push_req;
        end
    end

    assign head     = entries[rd_ptr];
    assign nonempty = (count != '0);
    // margin of one entry covers the registered ready
    assign space    = (count <= (FIFO_PTR_W + 1)'(FIFO_DEPTH - 2));

endmodule

//--- banked_mem/rsp_merge.sv
// ==============================
// joins both engines' read results into one stream
// group a wins a tie, group b waits one cycle in the skid slot
// ==============================

`timescale 1ns/1ps

module rsp_merge (
    input  logic                             itf,
    input  logic                             arst_n,
    input  logic                             rsp_valid_a,
    input  banked_mem_pkg::mem_rsp_t         rsp_a,
    input  logic                             rsp_valid_b,
    input  banked_mem_pkg::mem_rsp_t         rsp_b,
    output logic                             rvalid,
    output logic [banked_mem_pkg::ADDR_W-1:0] raddr,
    output logic [banked_mem_pkg::DATA_W-1:0] rdata
);

    import banked_mem_pkg::*;

    logic     skid_valid;
    mem_rsp_t skid;
    mem_rsp_t out_rsp;

    logic     out_valid_d;
    mem_rsp_t out_d;
    logic     skid_valid_d;
    mem_rsp_t skid_d;

    always_comb begin
        out_valid_d  = 1'b0;
        out_d        = rsp_a;
        skid_valid_d = 1'b0;
        skid_d       = rsp_b;
        if (skid_valid) begin
            // older entry first, a new one takes the slot
            out_valid_d  = 1'b1;
            out_d        = skid;
            skid_valid_d = rsp_valid_a || rsp_valid_b;
            skid_d       = rsp_valid_a ? rsp_a : rsp_b;
        end else if (rsp_valid_a) begin
            out_valid_d  = 1'b1;
            skid_valid_d = rsp_valid_b;
        end else if (rsp_valid_b) begin
            out_valid_d = 1'b1;
            out_d       = rsp_b;
        end
    end

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            rvalid     <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            rvalid     <= out_valid_d;
            skid_valid <= skid_valid_d;
        end
    end

    always_ff @(posedge itf) begin
        if (out_valid_d) begin
            out_rsp <= out_d;
        end
        if (skid_valid_d) begin
            skid <= skid_d;
        end
    end

    assign raddr = out_rsp.raddr;
    assign rdata = out_rsp.rdata;

endmodule

//--- common/banked_mem_pkg.sv
// ==============================
// shared types and constants for the banked memory
// address layout is {row, bank, col, offset}
// all timing values are in itf cycles
// ==============================

package banked_mem_pkg;

    // address fields
    localparam int OFFSET_W = 3;
    localparam int COL_W    = 3;
    localparam int BANK_W   = 2;
    localparam int ROW_W    = 4;
    localparam int ADDR_W   = OFFSET_W + COL_W + BANK_W + ROW_W;

    localparam int COL_LSB  = OFFSET_W;
    localparam int BANK_LSB = OFFSET_W + COL_W;      // bit 0 picks the group
    localparam int ROW_LSB  = BANK_LSB + BANK_W;

    // data and banks
    localparam int DATA_W      = 64;
    localparam int NUM_BANKS   = 2 ** BANK_W;
    localparam int GROUP_BANKS = NUM_BANKS / 2;
    localparam int LBANK_W     = $clog2(GROUP_BANKS);

    // timing
    localparam int T_RCD = 2;
    localparam int T_CL  = 2;
    localparam int T_WR  = 1;
    localparam int T_RP  = 2;
    localparam int T_RAS = 4;

    // wide enough for the largest timing value
    localparam int CNT_W = 3;

    // request queue
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              read;     // 0 means write
    } mem_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] raddr;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        PRECHARGE,
        ACTIVATE,
        ACCESS,
        COMPLETE
    } bank_state_e;

endpackage

//--- design/banked_mem_top.sv
// ==============================
// banked memory top level
// even banks go to one engine, odd banks to the other
// read results come back on rvalid, tagged by raddr
// ==============================

`timescale 1ns/1ps

module banked_mem_top (
    input  logic                              itf,
    input  logic                              arst_n,
    input  logic                              read,
    input  logic                              write,
    input  logic [banked_mem_pkg::ADDR_W-1:0] addr,
    input  logic [banked_mem_pkg::DATA_W-1:0] wdata,
    output logic                              ready,
    output logic                              rvalid,
    output logic [banked_mem_pkg::ADDR_W-1:0] raddr,
    output logic [banked_mem_pkg::DATA_W-1:0] rdata,
    output logic                              error
);

    import banked_mem_pkg::*;

    mem_req_t req;
    mem_req_t head_even;
    mem_req_t head_odd;
    mem_rsp_t rsp_even;
    mem_rsp_t rsp_odd;

    logic accept;
    logic odd_group;
    logic push_even;
    logic push_odd;
    logic pop_even;
    logic pop_odd;
    logic nonempty_even;
    logic nonempty_odd;
    logic space_even;
    logic space_odd;
    logic rsp_valid_even;
    logic rsp_valid_odd;
    logic bad_req;

    assign accept    = (read || write) && ready;
    assign odd_group = addr[BANK_LSB];
    assign push_even = accept && !odd_group;
    assign push_odd  = accept && odd_group;

    assign req = '{addr: addr, wdata: wdata, read: read};

    // both levels at once, or a misaligned word
    assign bad_req = (read && write) || (addr[OFFSET_W-1:0] != '0);

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            ready <= 1'b0;
            error <= 1'b0;
        end else begin
            ready <= space_even && space_odd;
            if (accept && bad_req) begin
                error <= 1'b1;      // sticky
            end
        end
    end

    req_fifo u_fifo_even (
        .itf      (itf),
        .arst_n   (arst_n),
        .push     (push_even),
        .push_req (req),
        .pop      (pop_even),
        .head     (head_even),
        .nonempty (nonempty_even),
        .space    (space_even)
    );

    req_fifo u_fifo_odd (
        .itf      (itf),
        .arst_n   (arst_n),
        .push     (push_odd),
        .push_req (req),
        .pop      (pop_odd),
        .head     (head_odd),
        .nonempty (nonempty_odd),
        .space    (space_odd)
    );

    bank_engine u_engine_even (
        .itf       (itf),
        .arst_n    (arst_n),
        .head      (head_even),
        .nonempty  (nonempty_even),
        .pop       (pop_even),
        .rsp_valid (rsp_valid_even),
        .rsp       (rsp_even)
    );

    bank_engine u_engine_odd (
        .itf       (itf),
        .arst_n    (arst_n),
        .head      (head_odd),
        .nonempty  (nonempty_odd),
        .pop       (pop_odd),
        .rsp_valid (rsp_valid_odd),
        .rsp       (rsp_odd)
    );

    rsp_merge u_merge (
        .itf         (itf),
        .arst_n      (arst_n),
        .rsp_valid_a (rsp_valid_even),
        .rsp_a       (rsp_even),
        .rsp_valid_b (rsp_valid_odd),
        .rsp_b       (rsp_odd),
        .rvalid      (rvalid),
        .raddr       (raddr),
        .rdata       (rdata)
    );

endmodule

//--- src.f
common/banked_mem_pkg.sv
banked_mem/req_fifo.sv
banked_mem/bank_engine.sv
banked_mem/rsp_merge.sv
design/banked_mem_top.sv
tb/tb_clk_gen.sv
tb/banked_mem_tb.sv

//--- tb/banked_mem_tb.sv
// ==============================
// testbench for the banked memory top level
// a word model and one expected queue per bank group
// check every rvalid, the error flag and the reset state
// ==============================

`timescale 1ns/1ps

module banked_mem_tb;

    import banked_mem_pkg::*;

    logic              itf;
    logic              arst_n;
    logic              restart;
    logic              read;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              ready;
    logic              rvalid;
    logic [ADDR_W-1:0] raddr;
    logic [DATA_W-1:0] rdata;
    logic              error;

    integer      seed = 40896;
    int          issued = 0;
    int          cycles = 0;
    string       test_name = "reset";
    logic        err_exp = 1'b0;
    logic        saw_stall = 1'b0;
    logic [DATA_W-1:0] model_mem [2 ** (ADDR_W - OFFSET_W)];
    mem_rsp_t    exp_q0 [$];      // even group
    mem_rsp_t    exp_q1 [$];      // odd group
    logic [ADDR_W-1:0] written_q [$];

    tb_clk_gen u_clk_gen (
        .restart (restart),
        .itf     (itf),
        .arst_n  (arst_n)
    );

    banked_mem_top u_dut (
        .itf    (itf),
        .arst_n (arst_n),
        .read   (read),
        .write  (write),
        .addr   (addr),
        .wdata  (wdata),
        .ready  (ready),
        .rvalid (rvalid),
        .raddr  (raddr),
        .rdata  (rdata),
        .error  (error)
    );

    task automatic report_mismatch(input string what, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        $display("** Error %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
        $display("Testbench failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string why);
        $display("%s: %s", test_name, why);
        $display("Testbench failed");
        $fatal(1, "stopped on failure");
    endtask

    function automatic logic [DATA_W-1:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // aligned address in the given bank with the row masked
    function automatic logic [ADDR_W-1:0] pick_addr(input logic [BANK_W-1:0] bank,
                                                    input logic [ROW_W-1:0] row_mask);
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
        row = ROW_W'($random(seed)) & row_mask;
        col = COL_W'($random(seed));
        return {row, bank, col, {OFFSET_W{1'b0}}};
    endfunction

    // holds the request until ready and updates the model at the accepting edge
    task automatic issue(input logic rd, input logic wr, input logic [ADDR_W-1:0] a,
                         input logic [DATA_W-1:0] d);
        mem_rsp_t e;
        issued++;
        @(negedge itf);
        read  = rd;
        write = wr;
        addr  = a;
        wdata = d;
        while (!ready) begin
            saw_stall = 1'b1;
            @(negedge itf);
        end
        @(posedge itf);
        if (rd) begin
            e.raddr = a;
            e.rdata = model_mem[a[ADDR_W-1:OFFSET_W]];
            if (a[BANK_LSB]) exp_q1.push_back(e);
            else             exp_q0.push_back(e);
        end else if (wr) begin
            model_mem[a[ADDR_W-1:OFFSET_W]] = d;
            written_q.push_back(a);
        end
        if ((rd && wr) || (a[OFFSET_W-1:0] != '0)) err_exp = 1'b1;
    endtask

    // waits for outstanding reads up to a cycle limit
    task automatic drain();
        int waited;
        waited = 0;
        @(negedge itf);
        read  = 1'b0;
        write = 1'b0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && waited < 200) begin
            waited++;
            @(negedge itf);
        end
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            abort_run("expected reads left after the drain");
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge itf) begin : check_outputs
        mem_rsp_t exp_rsp;
        if (!arst_n) begin
            assert (!rvalid && !error && !ready)
                else abort_run("rvalid, error or ready high during reset");
        end else begin
            assert (error === err_exp) else report_mismatch("error", 64'(err_exp), 64'(error));
            if (rvalid) begin
                if (raddr[BANK_LSB] ? (exp_q1.size() == 0) : (exp_q0.size() == 0)) begin
                    abort_run($sformatf("rvalid for %h with no read outstanding", raddr));
                end else begin
                    if (raddr[BANK_LSB]) exp_rsp = exp_q1.pop_front();
                    else                 exp_rsp = exp_q0.pop_front();
                    assert (raddr === exp_rsp.raddr)
                        else report_mismatch("raddr", 64'(exp_rsp.raddr), 64'(raddr));
                    assert (rdata === exp_rsp.rdata)
                        else report_mismatch("rdata", exp_rsp.rdata, rdata);
                end
            end
        end
    end

    always @(posedge itf) begin
        cycles++;
        if (cycles > 200 * issued + 500) begin
            abort_run($sformatf("no progress, run passed %0d cycles", cycles));
        end
    end

    initial begin
        logic [ADDR_W-1:0] addrs [8];
        read    = 1'b0;
        write   = 1'b0;
        addr    = '0;
        wdata   = '0;
        restart = 1'b0;
        @(posedge arst_n);

        test_name = "write_read";
        for (int i = 0; i < 8; i++) begin
            addrs[i] = pick_addr(BANK_W'($random(seed)), 4'hf);
            issue(1'b0, 1'b1, addrs[i], rand_word());
            issue(1'b1, 1'b0, addrs[i], '0);
        end
        drain();

        // few even-group rows so hits and conflicts mix
        test_name = "group_order";
        for (int i = 0; i < 8; i++) begin
            addrs[i] = pick_addr({1'($random(seed)), 1'b0}, 4'h3);
            issue(1'b0, 1'b1, addrs[i], rand_word());
        end
        for (int i = 7; i >= 0; i--) issue(1'b1, 1'b0, addrs[i], '0);
        for (int i = 0; i < 8; i++) issue(1'b1, 1'b0, addrs[i], '0);
        drain();

        test_name = "both_groups";
        for (int i = 0; i < 8; i++) begin
            addrs[i] = pick_addr(BANK_W'(i % NUM_BANKS), 4'hf);
            issue(1'b0, 1'b1, addrs[i], rand_word());
        end
        for (int n = 0; n < 2; n++) begin
            for (int i = 0; i < 8; i++) issue(1'b1, 1'b0, addrs[i], '0);
        end
        drain();

        // bank 1 with alternating rows keeps every access in conflict
        test_name = "back_pressure";
        saw_stall = 1'b0;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = {(i % 2 == 0) ? 4'h0 : 4'h9, 2'd1, 3'(i), 3'b000};
            issue(1'b0, 1'b1, addrs[i], rand_word());
        end
        for (int i = 0; i < 8; i++) issue(1'b1, 1'b0, addrs[i], '0);
        assert (saw_stall) else abort_run("ready never fell during the conflict burst");
        drain();

        test_name = "error_flag";
        issue(1'b1, 1'b0, written_q[0] | ADDR_W'(5), '0);    // misaligned
        drain();
        repeat (10) @(negedge itf);
        @(negedge itf);
        restart = 1'b1;
        @(negedge arst_n);
        restart = 1'b0;
        err_exp = 1'b0;
        @(posedge arst_n);
        issue(1'b1, 1'b1, written_q[1], rand_word());     // read and write together
        drain();
        repeat (10) @(negedge itf);

        repeat (20) @(negedge itf);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- tb/tb_clk_gen.sv
// ==============================
// testbench clock and reset source
// itf runs at 40 ns, arst_n is held low for 16 cycles
// a pulse on restart starts another reset
// ==============================

`timescale 1ns/1ps

module tb_clk_gen (
    input  logic restart,
    output logic itf,
    output logic arst_n
);

    initial itf = 1'b0;
    always #20 itf = ~itf;

    // reset edges sit a quarter period after the rising edge
    initial begin
        arst_n = 1'b0;
        forever begin
            repeat (16) @(posedge itf);
            #10 arst_n = 1'b1;
            @(posedge restart);
            @(posedge itf);
            #10 arst_n = 1'b0;
        end
    end

endmodule
